/* verilog/periph_pkg.sv */
package periph_pkg;

  // bus geometry
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int STRB_W   = 4;
  // low address bits that index inside one slave window (64 KiB)
  localparam int WIN_BITS = 16;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } axil_resp_e;

  typedef enum logic [3:0] {
    GPIO_DATA_IN  = 4'h0,
    GPIO_DATA_OUT = 4'h4
  } gpio_reg_e;

  typedef enum logic [3:0] {
    UART_RX   = 4'h0,
    UART_TX   = 4'h4,
    UART_STAT = 4'h8
  } uart_reg_e;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_e;

  // uart status word
  localparam int STAT_RX_VALID = 0;
  localparam int STAT_TX_EMPTY = 2;
  localparam int STAT_TX_FULL  = 3;

  // master to slave
  typedef struct packed {
    logic              aw_valid;
    logic [ADDR_W-1:0] aw_addr;
    logic              w_valid;
    logic [DATA_W-1:0] w_data;
    logic [STRB_W-1:0] w_strb;
    logic              b_ready;
    logic              ar_valid;
    logic [ADDR_W-1:0] ar_addr;
    logic              r_ready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic              aw_ready;
    logic              w_ready;
    logic              b_valid;
    axil_resp_e        b_resp;
    logic              ar_ready;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    axil_resp_e        r_resp;
  } axil_rsp_t;

endpackage

/* verilog/uart_phy.sv */
`timescale 1ns/1ps

module uart_phy #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       axi_aclk,
  input  logic       arst_n,
  input  logic [7:0] tx_data,
  input  logic       tx_load,
  output logic       tx_busy,
  output logic       txd,
  input  logic       rxd,
  output logic [7:0] rx_data,
  output logic       rx_strobe
);
  import periph_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  uart_state_e      tx_state;
  logic [CNT_W-1:0] tx_cnt;
  logic [2:0]       tx_idx;
  logic [7:0]       tx_shift;
  logic             tx_tick;
  uart_state_e      rx_state;
  logic [CNT_W-1:0] rx_cnt;
  logic [2:0]       rx_idx;
  logic [1:0]       rx_sync;
  logic             rx_last;
  logic             rx_bit;

  //////////////////////////////////////////////////////////////////////
  // transmit, start + 8 data lsb first + stop
  //////////////////////////////////////////////////////////////////////
  assign tx_busy = (tx_state != IDLE);
  assign tx_tick = (tx_cnt == BIT_LAST);

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      tx_state <= IDLE;
      tx_cnt   <= '0;
      tx_idx   <= '0;
      txd      <= 1'b1;
    end else begin
      tx_cnt <= (tx_state == IDLE || tx_tick) ? '0 : tx_cnt + 1'b1;
      case (tx_state)
        IDLE: if (tx_load) begin
          tx_state <= START;
          txd      <= 1'b0;
        end
        START: if (tx_tick) begin
          tx_state <= DATA;
          tx_idx   <= '0;
          txd      <= tx_shift[0];
        end
        DATA: if (tx_tick) begin
          tx_idx <= tx_idx + 1'b1;
          txd    <= tx_shift[1];
          if (tx_idx == 3'd7) begin
            tx_state <= STOP;
            txd      <= 1'b1;
          end
        end
        default: if (tx_tick) tx_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (tx_state == IDLE && tx_load) tx_shift <= tx_data;
    else if (tx_state == DATA && tx_tick) tx_shift <= tx_shift >> 1;
  end

  //////////////////////////////////////////////////////////////////////
  // receive, sampled at mid-bit
  //////////////////////////////////////////////////////////////////////
  assign rx_bit = rx_sync[1];

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      rx_sync   <= 2'b11;
      rx_last   <= 1'b1;
      rx_state  <= IDLE;
      rx_cnt    <= '0;
      rx_idx    <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_sync   <= {rx_sync[0], rxd};
      rx_last   <= rx_bit;
      rx_strobe <= 1'b0;
      rx_cnt    <= rx_cnt + 1'b1;
      case (rx_state)
        IDLE: begin
          rx_cnt <= '0;
          if (rx_last && !rx_bit) rx_state <= START;
        end
        START: if (rx_cnt == HALF_LAST) begin
          // false start if the line went back high
          rx_state <= rx_bit ? IDLE : DATA;
          rx_cnt   <= '0;
          rx_idx   <= '0;
        end
        DATA: if (rx_cnt == BIT_LAST) begin
          rx_cnt <= '0;
          rx_idx <= rx_idx + 1'b1;
          if (rx_idx == 3'd7) rx_state <= STOP;
        end
        default: if (rx_cnt == BIT_LAST) begin
          rx_state  <= IDLE;
          rx_strobe <= rx_bit;
        end
      endcase
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (rx_state == DATA && rx_cnt == BIT_LAST) rx_data <= {rx_bit, rx_data[7:1]};
  end

  // line idles high between frames
  a_txd_idle: assert property (@(posedge axi_aclk) disable iff (!arst_n)
    tx_state == IDLE |-> txd);

endmodule

/* verilog/axil_decoder.sv */
`timescale 1ns/1ps

module axil_decoder #(
  parameter logic [periph_pkg::ADDR_W-1:0] GPIO_BASE = 32'h4000_0000,
  parameter logic [periph_pkg::ADDR_W-1:0] UART_BASE = 32'h4060_0000
) (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  input  periph_pkg::axil_req_t s_req,
  output periph_pkg::axil_rsp_t s_rsp,
  output periph_pkg::axil_req_t gpio_req,
  input  periph_pkg::axil_rsp_t gpio_rsp,
  output periph_pkg::axil_req_t uart_req,
  input  periph_pkg::axil_rsp_t uart_rsp
);
  import periph_pkg::*;

  typedef enum logic [1:0] {
    TGT_GPIO,
    TGT_UART,
    TGT_NONE
  } tgt_e;

  // decoded from the live address
  tgt_e aw_tgt;
  tgt_e ar_tgt;
  // held from acceptance until the response transfers
  tgt_e w_tgt;
  tgt_e r_tgt;
  logic w_busy;
  logic r_busy;
  logic w_acc;
  logic r_acc;

  function automatic tgt_e decode(input logic [ADDR_W-1:0] addr);
    if (addr[ADDR_W-1:WIN_BITS] == GPIO_BASE[ADDR_W-1:WIN_BITS]) return TGT_GPIO;
    if (addr[ADDR_W-1:WIN_BITS] == UART_BASE[ADDR_W-1:WIN_BITS]) return TGT_UART;
    return TGT_NONE;
  endfunction

  assign aw_tgt = decode(s_req.aw_addr);
  assign ar_tgt = decode(s_req.ar_addr);

  //////////////////////////////////////////////////////////////////////
  // forward path, valids only reach the selected slave
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    gpio_req = s_req;
    uart_req = s_req;
    gpio_req.aw_valid = s_req.aw_valid && !w_busy && (aw_tgt == TGT_GPIO);
    gpio_req.w_valid  = s_req.w_valid && !w_busy && (aw_tgt == TGT_GPIO);
    gpio_req.b_ready  = s_req.b_ready && w_busy && (w_tgt == TGT_GPIO);
    gpio_req.ar_valid = s_req.ar_valid && !r_busy && (ar_tgt == TGT_GPIO);
    gpio_req.r_ready  = s_req.r_ready && r_busy && (r_tgt == TGT_GPIO);
    uart_req.aw_valid = s_req.aw_valid && !w_busy && (aw_tgt == TGT_UART);
    uart_req.w_valid  = s_req.w_valid && !w_busy && (aw_tgt == TGT_UART);
    uart_req.b_ready  = s_req.b_ready && w_busy && (w_tgt == TGT_UART);
    uart_req.ar_valid = s_req.ar_valid && !r_busy && (ar_tgt == TGT_UART);
    uart_req.r_ready  = s_req.r_ready && r_busy && (r_tgt == TGT_UART);
  end

  //////////////////////////////////////////////////////////////////////
  // return path
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    s_rsp = '0;
    if (!w_busy) begin
      case (aw_tgt)
        TGT_GPIO: begin
          s_rsp.aw_ready = gpio_rsp.aw_ready;
          s_rsp.w_ready  = gpio_rsp.w_ready;
        end
        TGT_UART: begin
          s_rsp.aw_ready = uart_rsp.aw_ready;
          s_rsp.w_ready  = uart_rsp.w_ready;
        end
        default: begin
          // unmapped, swallow it here
          s_rsp.aw_ready = s_req.aw_valid && s_req.w_valid;
          s_rsp.w_ready  = s_req.aw_valid && s_req.w_valid;
        end
      endcase
    end else begin
      case (w_tgt)
        TGT_GPIO: begin
          s_rsp.b_valid = gpio_rsp.b_valid;
          s_rsp.b_resp  = gpio_rsp.b_resp;
        end
        TGT_UART: begin
          s_rsp.b_valid = uart_rsp.b_valid;
          s_rsp.b_resp  = uart_rsp.b_resp;
        end
        default: begin
          s_rsp.b_valid = 1'b1;
          s_rsp.b_resp  = DECERR;
        end
      endcase
    end
    if (!r_busy) begin
      case (ar_tgt)
        TGT_GPIO: s_rsp.ar_ready = gpio_rsp.ar_ready;
        TGT_UART: s_rsp.ar_ready = uart_rsp.ar_ready;
        default:  s_rsp.ar_ready = s_req.ar_valid;
      endcase
    end else begin
      case (r_tgt)
        TGT_GPIO: begin
          s_rsp.r_valid = gpio_rsp.r_valid;
          s_rsp.r_data  = gpio_rsp.r_data;
          s_rsp.r_resp  = gpio_rsp.r_resp;
        end
        TGT_UART: begin
          s_rsp.r_valid = uart_rsp.r_valid;
          s_rsp.r_data  = uart_rsp.r_data;
          s_rsp.r_resp  = uart_rsp.r_resp;
        end
        default: begin
          // r_data stays 0
          s_rsp.r_valid = 1'b1;
          s_rsp.r_resp  = DECERR;
        end
      endcase
    end
  end

  assign w_acc = s_req.aw_valid && s_req.w_valid && s_rsp.aw_ready && s_rsp.w_ready;
  assign r_acc = s_req.ar_valid && s_rsp.ar_ready;

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      w_busy <= 1'b0;
      r_busy <= 1'b0;
      w_tgt  <= TGT_NONE;
      r_tgt  <= TGT_NONE;
    end else begin
      if (w_acc) begin
        w_busy <= 1'b1;
        w_tgt  <= aw_tgt;
      end else if (s_rsp.b_valid && s_req.b_ready) begin
        w_busy <= 1'b0;
      end
      if (r_acc) begin
        r_busy <= 1'b1;
        r_tgt  <= ar_tgt;
      end else if (s_rsp.r_valid && s_req.r_ready) begin
        r_busy <= 1'b0;
      end
    end
  end

  // write response must wait for the master
  a_b_hold: assert property (@(posedge axi_aclk) disable iff (!arst_n)
    s_rsp.b_valid && !s_req.b_ready |=> s_rsp.b_valid);

endmodule

/* verilog/axil_gpio.sv */
`timescale 1ns/1ps

module axil_gpio #(
  parameter int GPIO_W = 8
) (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  input  periph_pkg::axil_req_t req,
  output periph_pkg::axil_rsp_t rsp,
  input  logic [GPIO_W-1:0]     gpio_in,
  output logic [GPIO_W-1:0]     gpio_out
);
  import periph_pkg::*;

  logic [GPIO_W-1:0] in_q;
  logic              wr_ready;
  logic              rd_ready;
  logic              b_valid;
  logic              r_valid;
  logic [DATA_W-1:0] r_data;
  logic              wr_low;
  logic              rd_low;

  // one write and one read at a time
  assign wr_ready = req.aw_valid && req.w_valid && !b_valid;
  assign rd_ready = req.ar_valid && !r_valid;
  // offsets above the register block read as zero
  assign wr_low = (req.aw_addr[WIN_BITS-1:4] == '0);
  assign rd_low = (req.ar_addr[WIN_BITS-1:4] == '0);

  always_ff @(posedge axi_aclk) begin
    in_q <= gpio_in;
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_out <= '0;
    end else if (wr_ready && wr_low && req.aw_addr[3:0] == GPIO_DATA_OUT) begin
      // byte lanes by strobe
      for (int i = 0; i < GPIO_W; i++) begin
        if (req.w_strb[i/8]) gpio_out[i] <= req.w_data[i];
      end
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      b_valid <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      if (wr_ready) b_valid <= 1'b1;
      else if (req.b_ready) b_valid <= 1'b0;
      if (rd_ready) r_valid <= 1'b1;
      else if (req.r_ready) r_valid <= 1'b0;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (rd_ready) begin
      r_data <= '0;
      if (rd_low && req.ar_addr[3:0] == GPIO_DATA_IN) r_data <= DATA_W'(in_q);
      if (rd_low && req.ar_addr[3:0] == GPIO_DATA_OUT) r_data <= DATA_W'(gpio_out);
    end
  end

  always_comb begin
    rsp          = '0;
    rsp.aw_ready = wr_ready;
    rsp.w_ready  = wr_ready;
    rsp.b_valid  = b_valid;
    rsp.b_resp   = OKAY;
    rsp.ar_ready = rd_ready;
    rsp.r_valid  = r_valid;
    rsp.r_data   = r_data;
    rsp.r_resp   = OKAY;
  end

  // no new read reaches the block while a response is pending
  a_r_pending: assert property (@(posedge axi_aclk) disable iff (!arst_n)
    r_valid |-> !req.ar_valid);

endmodule

/* verilog/axil_uartlite.sv */
`timescale 1ns/1ps

module axil_uartlite #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  input  periph_pkg::axil_req_t req,
  output periph_pkg::axil_rsp_t rsp,
  input  logic                  uart_rxd,
  output logic                  uart_txd
);
  import periph_pkg::*;

  logic [7:0]        tx_hold;
  logic              tx_full;
  logic              tx_load;
  logic              tx_busy;
  logic [7:0]        rx_hold;
  logic              rx_valid;
  logic [7:0]        rx_data;
  logic              rx_strobe;
  logic              wr_ready;
  logic              rd_ready;
  logic              b_valid;
  logic              r_valid;
  logic [DATA_W-1:0] r_data;
  logic              tx_write;
  logic              rx_pop;
  logic [DATA_W-1:0] stat;

  assign wr_ready = req.aw_valid && req.w_valid && !b_valid;
  assign rd_ready = req.ar_valid && !r_valid;
  assign tx_write = wr_ready && req.w_strb[0] && (req.aw_addr[WIN_BITS-1:4] == '0) &&
                    (req.aw_addr[3:0] == UART_TX);
  assign rx_pop   = rd_ready && (req.ar_addr[WIN_BITS-1:4] == '0) &&
                    (req.ar_addr[3:0] == UART_RX);
  // hand the byte over as soon as the serializer is free
  assign tx_load  = tx_full && !tx_busy;

  always_comb begin
    stat                = '0;
    stat[STAT_RX_VALID] = rx_valid;
    stat[STAT_TX_EMPTY] = !tx_full;
    stat[STAT_TX_FULL]  = tx_full;
  end

  //////////////////////////////////////////////////////////////////////
  // holding registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      tx_full  <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      // a byte written while full is dropped
      if (tx_write && !tx_full) tx_full <= 1'b1;
      else if (tx_load) tx_full <= 1'b0;
      if (rx_pop) rx_valid <= 1'b0;
      if (rx_strobe) rx_valid <= 1'b1;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (tx_write && !tx_full) tx_hold <= req.w_data[7:0];
    if (rx_strobe) rx_hold <= rx_data;
  end

  //////////////////////////////////////////////////////////////////////
  // bus responses
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      b_valid <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      if (wr_ready) b_valid <= 1'b1;
      else if (req.b_ready) b_valid <= 1'b0;
      if (rd_ready) r_valid <= 1'b1;
      else if (req.r_ready) r_valid <= 1'b0;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (rd_ready) begin
      r_data <= '0;
      if (rx_pop && rx_valid) r_data <= DATA_W'(rx_hold);
      if ((req.ar_addr[WIN_BITS-1:4] == '0) && (req.ar_addr[3:0] == UART_STAT)) begin
        r_data <= stat;
      end
    end
  end

  always_comb begin
    rsp          = '0;
    rsp.aw_ready = wr_ready;
    rsp.w_ready  = wr_ready;
    rsp.b_valid  = b_valid;
    rsp.b_resp   = OKAY;
    rsp.ar_ready = rd_ready;
    rsp.r_valid  = r_valid;
    rsp.r_data   = r_data;
    rsp.r_resp   = OKAY;
  end

  uart_phy #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_phy (
    .axi_aclk  (axi_aclk),
    .arst_n    (arst_n),
    .tx_data   (tx_hold),
    .tx_load   (tx_load),
    .tx_busy   (tx_busy),
    .txd       (uart_txd),
    .rxd       (uart_rxd),
    .rx_data   (rx_data),
    .rx_strobe (rx_strobe)
  );

  // the serializer takes the byte and reports busy
  a_tx_load: assert property (@(posedge axi_aclk) disable iff (!arst_n)
    tx_load |=> tx_busy);

endmodule

/* verilog/periph_shell.sv */
`timescale 1ns/1ps

module periph_shell #(
  parameter logic [periph_pkg::ADDR_W-1:0] GPIO_BASE    = 32'h4000_0000,
  parameter logic [periph_pkg::ADDR_W-1:0] UART_BASE    = 32'h4060_0000,
  parameter int                            GPIO_W       = 8,
  parameter int                            CLKS_PER_BIT = 868
) (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  input  periph_pkg::axil_req_t s_axil_req,
  output periph_pkg::axil_rsp_t s_axil_rsp,
  input  logic [GPIO_W-1:0]     gpio_in,
  output logic [GPIO_W-1:0]     gpio_out,
  input  logic                  uart_rxd,
  output logic                  uart_txd
);
  import periph_pkg::*;

  axil_req_t gpio_req;
  axil_rsp_t gpio_rsp;
  axil_req_t uart_req;
  axil_rsp_t uart_rsp;

  axil_decoder #(
    .GPIO_BASE (GPIO_BASE),
    .UART_BASE (UART_BASE)
  ) u_decoder (
    .axi_aclk (axi_aclk),
    .arst_n   (arst_n),
    .s_req    (s_axil_req),
    .s_rsp    (s_axil_rsp),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp),
    .uart_req (uart_req),
    .uart_rsp (uart_rsp)
  );

  axil_gpio #(
    .GPIO_W (GPIO_W)
  ) u_gpio (
    .axi_aclk (axi_aclk),
    .arst_n   (arst_n),
    .req      (gpio_req),
    .rsp      (gpio_rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

  axil_uartlite #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uartlite (
    .axi_aclk (axi_aclk),
    .arst_n   (arst_n),
    .req      (uart_req),
    .rsp      (uart_rsp),
    .uart_rxd (uart_rxd),
    .uart_txd (uart_txd)
  );

endmodule

/* tb/tb_periph_shell.sv */
`timescale 1ns/1ps

module tb_periph_shell;
  import periph_pkg::*;

  localparam int          CLKS_PER_BIT = 8;
  localparam int          GPIO_W       = 8;
  localparam logic [31:0] GPIO_BASE    = 32'h4000_0000;
  localparam logic [31:0] UART_BASE    = 32'h4060_0000;
  localparam int          CLK_NS       = 4;
  localparam int          FRAME_NS     = 10 * CLKS_PER_BIT * CLK_NS;
  localparam int          N_TESTS      = 6;
  // 40 frame times per test
  localparam int          TIMEOUT_NS   = N_TESTS * 40 * FRAME_NS;

  logic              axi_aclk;
  logic              arst_n;
  axil_req_t         req;
  axil_rsp_t         rsp;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic              uart_line;

  // {resp, data} pairs waiting for the compare process
  logic [33:0] exp_q[$];
  logic [33:0] obs_q[$];
  bit          wr_q[$];

  int errors       = 0;
  int test_base    = 0;
  int tests_failed = 0;

  // register models
  logic [GPIO_W-1:0] gout_m;
  logic [GPIO_W-1:0] gin_m;
  // {tx_empty, rx_valid, rx byte}
  logic [9:0]        uart_m;

  periph_shell #(
    .GPIO_BASE    (GPIO_BASE),
    .UART_BASE    (UART_BASE),
    .GPIO_W       (GPIO_W),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) dut_i (
    .axi_aclk   (axi_aclk),
    .arst_n     (arst_n),
    .s_axil_req (req),
    .s_axil_rsp (rsp),
    .gpio_in    (gpio_in),
    .gpio_out   (gpio_out),
    .uart_rxd   (uart_line),
    .uart_txd   (uart_line)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #(CLK_NS / 2) axi_aclk = ~axi_aclk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [33:0] ref_read(input logic [31:0] addr,
                                           input logic [GPIO_W-1:0] gin,
                                           input logic [GPIO_W-1:0] gout,
                                           input logic [9:0] um);
    logic [1:0]  resp;
    logic [31:0] data;
    resp = OKAY;
    data = 32'h0;
    if (addr[31:16] == GPIO_BASE[31:16]) begin
      case (addr[15:0])
        16'h0000: data = 32'(gin);
        16'h0004: data = 32'(gout);
        default:  data = 32'h0;
      endcase
    end else if (addr[31:16] == UART_BASE[31:16]) begin
      case (addr[15:0])
        16'h0000: data = um[8] ? 32'(um[7:0]) : 32'h0;
        16'h0008: begin
          data[STAT_RX_VALID] = um[8];
          data[STAT_TX_EMPTY] = um[9];
          data[STAT_TX_FULL]  = !um[9];
        end
        default:  data = 32'h0;
      endcase
    end else begin
      resp = DECERR;
    end
    return {resp, data};
  endfunction

  // byte lanes of the output register follow the strobes
  function automatic logic [GPIO_W-1:0] merge_strb(input logic [GPIO_W-1:0] old,
                                                   input logic [31:0] data,
                                                   input logic [3:0] strb);
    logic [GPIO_W-1:0] res;
    res = old;
    for (int b = 0; b < GPIO_W; b++) begin
      if (strb[b / 8]) res[b] = data[b];
    end
    return res;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus transactions
  //////////////////////////////////////////////////////////////////////
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    @(posedge axi_aclk);
    req.aw_valid <= 1'b1;
    req.aw_addr  <= addr;
    req.w_valid  <= 1'b1;
    req.w_data   <= data;
    req.w_strb   <= strb;
    req.b_ready  <= 1'b1;
    @(negedge axi_aclk);
    while (!(rsp.aw_ready && rsp.w_ready)) @(negedge axi_aclk);
    @(posedge axi_aclk);
    req.aw_valid <= 1'b0;
    req.w_valid  <= 1'b0;
    // response one cycle after acceptance
    @(negedge axi_aclk);
    check_val("b_valid", 32'd1, 32'(rsp.b_valid));
    resp = rsp.b_resp;
    @(posedge axi_aclk);
    req.b_ready <= 1'b0;
    @(negedge axi_aclk);
    check_val("b_valid", 32'd0, 32'(rsp.b_valid));
  endtask

  task automatic read_word(input logic [31:0] addr, input int hold,
                           output logic [1:0] resp, output logic [31:0] data);
    logic [31:0] first;
    logic [1:0]  first_resp;
    @(posedge axi_aclk);
    req.ar_valid <= 1'b1;
    req.ar_addr  <= addr;
    @(negedge axi_aclk);
    while (!rsp.ar_ready) @(negedge axi_aclk);
    check_val("r_valid", 32'd0, 32'(rsp.r_valid));
    @(posedge axi_aclk);
    req.ar_valid <= 1'b0;
    req.r_ready  <= (hold == 0);
    @(negedge axi_aclk);
    check_val("r_valid", 32'd1, 32'(rsp.r_valid));
    first      = rsp.r_data;
    first_resp = rsp.r_resp;
    // master stalls, the response must not move
    for (int i = 0; i < hold; i++) begin
      @(posedge axi_aclk);
      @(negedge axi_aclk);
      check_val("r_valid", 32'd1, 32'(rsp.r_valid));
      check_val("r_data", first, rsp.r_data);
    end
    if (hold > 0) begin
      @(posedge axi_aclk);
      req.r_ready <= 1'b1;
      @(negedge axi_aclk);
      check_val("r_valid", 32'd1, 32'(rsp.r_valid));
      check_val("r_data", first, rsp.r_data);
    end
    @(posedge axi_aclk);
    req.r_ready <= 1'b0;
    @(negedge axi_aclk);
    check_val("r_valid", 32'd0, 32'(rsp.r_valid));
    resp = first_resp;
    data = first;
  endtask

  task automatic checked_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
    logic [33:0] r;
    logic [1:0]  resp;
    r = ref_read(addr, gin_m, gout_m, uart_m);
    exp_q.push_back({r[33:32], 32'h0});
    wr_q.push_back(1'b1);
    write_word(addr, data, strb, resp);
    obs_q.push_back({resp, 32'h0});
  endtask

  task automatic checked_read(input logic [31:0] addr, input int hold);
    logic [1:0]  resp;
    logic [31:0] data;
    exp_q.push_back(ref_read(addr, gin_m, gout_m, uart_m));
    wr_q.push_back(1'b0);
    read_word(addr, hold, resp, data);
    obs_q.push_back({resp, data});
  endtask

  task automatic poll_rx();
    time         t0;
    logic [1:0]  resp;
    logic [31:0] data;
    bit          seen;
    t0   = $time;
    seen = 1'b0;
    while (!seen && ($time - t0) < 64'(2 * FRAME_NS)) begin
      read_word(UART_BASE + 32'h8, 0, resp, data);
      check_val("r_resp", 32'(OKAY), 32'(resp));
      seen = data[STAT_RX_VALID];
    end
    assert (seen) else begin
      $display("uart loopback: received byte not flagged within two frame times");
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int n;
    @(posedge axi_aclk);
    @(negedge axi_aclk);
    n = errors - test_base;
    if (n == 0) begin
      $display("test %-12s passed", name);
    end else begin
      $display("test %-12s failed with %0d errors", name, n);
      tests_failed++;
    end
    test_base = errors;
  endtask

  // compare process
  initial begin : compare
    logic [33:0] e;
    logic [33:0] o;
    bit          w;
    forever begin
      @(posedge axi_aclk);
      while (obs_q.size() > 0) begin
        e = exp_q.pop_front();
        o = obs_q.pop_front();
        w = wr_q.pop_front();
        if (w) begin
          check_val("b_resp", 32'(e[33:32]), 32'(o[33:32]));
        end else begin
          check_val("r_resp", 32'(e[33:32]), 32'(o[33:32]));
          check_val("r_data", e[31:0], o[31:0]);
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] v;
    logic [31:0] s;
    logic [31:0] addr;
    int          hold;
    void'($urandom(84));
    req     <= '0;
    gpio_in <= '0;
    arst_n  <= 1'b0;
    gout_m  = '0;
    gin_m   = '0;
    uart_m  = {1'b1, 1'b0, 8'h00};
    repeat (4) @(posedge axi_aclk);
    arst_n <= 1'b1;

    @(negedge axi_aclk);
    check_val("b_valid", 32'd0, 32'(rsp.b_valid));
    check_val("r_valid", 32'd0, 32'(rsp.r_valid));
    check_val("gpio_out", 32'd0, 32'(gpio_out));
    check_val("uart_txd", 32'd1, 32'(uart_line));
    finish_test("reset");

    for (int i = 0; i < 8; i++) begin
      v = $urandom;
      s = $urandom;
      gout_m = merge_strb(gout_m, v, s[3:0]);
      checked_write(GPIO_BASE + 32'h4, v, s[3:0]);
      check_val("gpio_out", 32'(gout_m), 32'(gpio_out));
      checked_read(GPIO_BASE + 32'h4, 0);
    end
    finish_test("gpio_out");

    for (int i = 0; i < 8; i++) begin
      v = $urandom;
      @(posedge axi_aclk);
      gpio_in <= v[GPIO_W-1:0];
      gin_m = v[GPIO_W-1:0];
      @(posedge axi_aclk);
      checked_read(GPIO_BASE, 0);
    end
    finish_test("gpio_in");

    // txd is looped back to rxd
    for (int i = 0; i < 3; i++) begin
      v = $urandom;
      checked_write(UART_BASE + 32'h4, v, 4'h1);
      poll_rx();
      uart_m = {1'b1, 1'b1, v[7:0]};
      checked_read(UART_BASE, 0);
      uart_m[8] = 1'b0;
      checked_read(UART_BASE + 32'h8, 0);
    end
    finish_test("uart_loop");

    checked_read(32'h5000_0010, 0);
    checked_write(32'h5000_0000, $urandom, 4'hf);
    checked_read(GPIO_BASE + 32'h1_0000, 0);
    checked_read(GPIO_BASE + 32'h8, 0);
    checked_read(UART_BASE + 32'hc, 0);
    checked_read(UART_BASE + 32'h4, 0);
    checked_write(GPIO_BASE + 32'h8, $urandom, 4'hf);
    check_val("gpio_out", 32'(gout_m), 32'(gpio_out));
    finish_test("decode");

    for (int i = 0; i < 6; i++) begin
      hold = 2 + int'($urandom % 5);
      case (i % 4)
        0:       addr = GPIO_BASE + 32'h4;
        1:       addr = GPIO_BASE;
        2:       addr = 32'h7000_0000;
        default: addr = UART_BASE + 32'h8;
      endcase
      checked_read(addr, hold);
    end
    finish_test("backpressure");

    $display("%0d tests, %0d failed, %0d errors", N_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* sim.f */
verilog/periph_pkg.sv
verilog/uart_phy.sv
verilog/axil_decoder.sv
verilog/axil_gpio.sv
verilog/axil_uartlite.sv
verilog/periph_shell.sv
tb/tb_periph_shell.sv

/* Makefile */
# Verilator build and run for the peripheral shell testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_shell
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx 'NO ERRORS' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
